// ==== hw/tg_defines.svh ====
`ifndef TG_DEFINES_SVH
`define TG_DEFINES_SVH

// memory request port widths
`define TG_ADDR_W 24
`define TG_DATA_W 128

// incoming rgb565 sample colour
`define TG_PIX_W 16

// accumulator fields, red in the low bits of a lane
`define TG_RED_W 21
`define TG_GREEN_W 22
`define TG_BLUE_W 21
`define TG_LANE_W 64

// setting this address bit moves a request into the accumulator region
`define TG_ACCUM_BASE_BIT 21

// queue depths
`define TG_CMD_DEPTH 64
`define TG_WB_DEPTH 64

// 1280x720 pixels at 8 pixels per word
`define TG_RD_FRAME_WORDS 115200

`endif

// ==== hw/tg_pkg.sv ====
`include "tg_defines.svh"

package tg_pkg;

    // scheduler states, one cycle each after reset
    typedef enum logic [1:0] {
        RST,
        RD_DISP,
        RMW
    } tg_state_e;

    // what a memory request is for, kept with it until completion
    typedef enum logic [2:0] {
        NONE,
        READ_DISP,
        FETCH_ACC,
        // fetch whose writeback replaces the lane instead of adding
        FETCH_ACC_OW,
        WRITE_BACK_ACC
    } req_type_e;

    // one sample on the incoming stream
    typedef struct packed {
        logic [`TG_ADDR_W-1:0] addr;
        logic [`TG_PIX_W-1:0]  color;
        logic                  last;
    } sample_t;

    // request fields toward the ddr controller
    typedef struct packed {
        logic [`TG_ADDR_W-1:0] addr;
        logic                  we;
        logic [`TG_DATA_W-1:0] wdata;
    } mem_req_t;

    // issued request record, popped when its completion returns
    typedef struct packed {
        req_type_e             req_type;
        logic [`TG_ADDR_W-1:0] addr;
        logic [`TG_PIX_W-1:0]  color;
    } cmd_t;

    // pending accumulator writeback, addr is the pixel address
    typedef struct packed {
        logic [`TG_ADDR_W-1:0] addr;
        logic [`TG_DATA_W-1:0] data;
    } wb_t;

endpackage

// ==== hw/command_fifo.sv ====
module command_fifo #(
    parameter type cmd_type = logic [7:0],
    parameter int depth = 16
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    write,
    input  cmd_type din,
    input  logic    read,
    output cmd_type dout,
    output logic    full,
    output logic    empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
    // count needs one more bit than the pointers to tell full from empty
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

    cmd_type mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0] count;

    // storage, head is read straight from the array
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (write) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (read) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            // count unchanged on simultaneous read and write
            case ({write, read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign dout = mem[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == full_count);

    // the consumer only pops what the producer has pushed
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst) read |-> !empty)
        else $error("command_fifo read while empty");

    // the producer never overruns the queue
    a_no_write_full: assert property (@(posedge clk) disable iff (rst) write |-> !full)
        else $error("command_fifo write while full");

endmodule

// ==== hw/pixel_accumulate.sv ====
`include "tg_defines.svh"

module pixel_accumulate
    import tg_pkg::*;
(
    input  cmd_t                  head_cmd,
    input  logic [`TG_DATA_W-1:0] mem_rsp_data,
    output logic [`TG_DATA_W-1:0] acc_word
);

    logic                   overwrite;
    logic                   low_lane;
    logic [`TG_LANE_W-1:0]  old_lane;
    logic [`TG_LANE_W-1:0]  new_lane;
    logic [`TG_RED_W-1:0]   old_red;
    logic [`TG_GREEN_W-1:0] old_green;
    logic [`TG_BLUE_W-1:0]  old_blue;
    logic [`TG_RED_W-1:0]   pix_red;
    logic [`TG_GREEN_W-1:0] pix_green;
    logic [`TG_BLUE_W-1:0]  pix_blue;
    logic [`TG_RED_W-1:0]   new_red;
    logic [`TG_GREEN_W-1:0] new_green;
    logic [`TG_BLUE_W-1:0]  new_blue;

    assign overwrite = (head_cmd.req_type == FETCH_ACC_OW);
    // odd pixels live in the low lane
    assign low_lane = head_cmd.addr[0];

    assign old_lane = low_lane ? mem_rsp_data[`TG_LANE_W-1:0]
                               : mem_rsp_data[`TG_DATA_W-1:`TG_LANE_W];

    // lane layout: blue | green | red
    assign old_red = old_lane[`TG_RED_W-1:0];
    assign old_green = old_lane[`TG_RED_W +: `TG_GREEN_W];
    assign old_blue = old_lane[`TG_RED_W + `TG_GREEN_W +: `TG_BLUE_W];

    // rgb565 channels, zero extended to the field widths
    assign pix_red = {{(`TG_RED_W - 5){1'b0}}, head_cmd.color[4:0]};
    assign pix_green = {{(`TG_GREEN_W - 6){1'b0}}, head_cmd.color[10:5]};
    assign pix_blue = {{(`TG_BLUE_W - 5){1'b0}}, head_cmd.color[15:11]};

    // last sample of a pass starts the sum over
    assign new_red = overwrite ? pix_red : old_red + pix_red;
    assign new_green = overwrite ? pix_green : old_green + pix_green;
    assign new_blue = overwrite ? pix_blue : old_blue + pix_blue;

    assign new_lane = {new_blue, new_green, new_red};

    // other lane passes through untouched
    assign acc_word = low_lane ? {mem_rsp_data[`TG_DATA_W-1:`TG_LANE_W], new_lane}
                               : {new_lane, mem_rsp_data[`TG_LANE_W-1:0]};

endmodule

// ==== hw/request_scheduler.sv ====
`include "tg_defines.svh"

module request_scheduler
    import tg_pkg::*;
#(
    parameter int rd_frame_words = `TG_RD_FRAME_WORDS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  sample_t               sample,
    input  logic                  sample_valid,
    input  logic                  mem_busy,
    input  logic                  mem_complete,
    input  logic                  rd_almost_full,
    input  cmd_t                  head_cmd,
    input  logic                  wb_empty,
    input  wb_t                   wb_head,
    input  logic [`TG_DATA_W-1:0] acc_word,
    output logic                  sample_ready,
    output mem_req_t              mem_req,
    output logic                  mem_en,
    output cmd_t                  cmd_push,
    output logic                  cmd_push_en,
    output logic                  wb_push_en,
    output logic                  wb_pop,
    output logic                  rd_valid,
    output logic                  rd_last
);

    localparam logic [`TG_ADDR_W-1:0] disp_last = `TG_ADDR_W'(rd_frame_words - 1);
    localparam logic [`TG_ADDR_W-1:0] accum_base =
        {{(`TG_ADDR_W - 1){1'b0}}, 1'b1} << `TG_ACCUM_BASE_BIT;

    tg_state_e state;
    req_type_e req_type;
    logic [`TG_ADDR_W-1:0] disp_addr;
    logic [`TG_ADDR_W-1:0] wb_pixel;
    logic fetch_done;
    logic wb_needed;
    logic wb_direct;

    // display and accumulator traffic take turns every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST;
        end else begin
            case (state)
                RST: state <= RD_DISP;
                RD_DISP: state <= RMW;
                RMW: state <= RD_DISP;
                default: state <= RST;
            endcase
        end
    end

    // display word counter steps only on an accepted read
    always_ff @(posedge clk) begin
        if (rst) begin
            disp_addr <= '0;
        end else if (mem_en && req_type == READ_DISP) begin
            disp_addr <= (disp_addr == disp_last) ? '0 : disp_addr + 1'b1;
        end
    end

    // completing fetch has a repacked word ready this cycle
    assign fetch_done = mem_complete &&
        (head_cmd.req_type == FETCH_ACC || head_cmd.req_type == FETCH_ACC_OW);
    assign wb_needed = fetch_done || !wb_empty;

    // writebacks first so the queue drains before new fetches
    always_comb begin
        req_type = NONE;
        case (state)
            RD_DISP: begin
                if (!rd_almost_full) begin
                    req_type = READ_DISP;
                end
            end
            RMW: begin
                if (wb_needed) begin
                    req_type = WRITE_BACK_ACC;
                end else if (sample_valid) begin
                    req_type = sample.last ? FETCH_ACC_OW : FETCH_ACC;
                end
            end
            default: req_type = NONE;
        endcase
    end

    // the request is taken on this edge whenever en is high
    assign mem_en = (req_type != NONE) && !mem_busy;
    assign cmd_push_en = mem_en;

    // with an empty queue the writeback can only be the completing fetch
    assign wb_direct = mem_en && (req_type == WRITE_BACK_ACC) && wb_empty;
    assign wb_pop = mem_en && (req_type == WRITE_BACK_ACC) && !wb_empty;
    assign wb_push_en = fetch_done && !wb_direct;
    assign wb_pixel = wb_empty ? head_cmd.addr : wb_head.addr;

    // sample leaves the stream together with its fetch
    assign sample_ready = mem_en && (req_type == FETCH_ACC || req_type == FETCH_ACC_OW);

    always_comb begin
        mem_req = '0;
        cmd_push = '0;
        cmd_push.req_type = req_type;
        case (req_type)
            READ_DISP: begin
                mem_req.addr = disp_addr;
                cmd_push.addr = disp_addr;
            end
            FETCH_ACC, FETCH_ACC_OW: begin
                // two pixels per accumulator word
                mem_req.addr = (sample.addr >> 1) | accum_base;
                cmd_push.addr = sample.addr;
                cmd_push.color = sample.color;
            end
            WRITE_BACK_ACC: begin
                mem_req.addr = (wb_pixel >> 1) | accum_base;
                mem_req.we = 1'b1;
                mem_req.wdata = wb_empty ? acc_word : wb_head.data;
                cmd_push.addr = wb_pixel;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // display data goes out on the cycle it returns
    assign rd_valid = mem_complete && (head_cmd.req_type == READ_DISP);
    assign rd_last = rd_valid && (head_cmd.addr == disp_last);

    a_no_en_busy: assert property (@(posedge clk) disable iff (rst) mem_en |-> !mem_busy)
        else $error("request issued while controller busy");

    // a waiting sample must stay put until its fetch takes it
    a_sample_hold: assert property (@(posedge clk) disable iff (rst)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample))
        else $error("sample dropped or changed before its handshake");

endmodule

// ==== hw/traffic_generator.sv ====
`include "tg_defines.svh"

module traffic_generator
    import tg_pkg::*;
#(
    parameter int rd_frame_words = `TG_RD_FRAME_WORDS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  sample_t               sample,
    input  logic                  sample_valid,
    output logic                  sample_ready,
    output mem_req_t              mem_req,
    output logic                  mem_en,
    input  logic                  mem_busy,
    input  logic                  mem_complete,
    input  logic [`TG_DATA_W-1:0] mem_rsp_data,
    output logic [`TG_DATA_W-1:0] rd_data,
    output logic                  rd_valid,
    output logic                  rd_last,
    input  logic                  rd_almost_full
);

    // issued-request queue
    cmd_t cmd_push;
    cmd_t head_cmd;
    logic cmd_push_en;

    // writeback queue
    wb_t wb_push;
    wb_t wb_head;
    logic wb_push_en;
    logic wb_pop;
    logic wb_empty;

    logic [`TG_DATA_W-1:0] acc_word;

    // queued writeback keeps the pixel address for lane and word select
    assign wb_push.addr = head_cmd.addr;
    assign wb_push.data = acc_word;

    // display stream carries the raw controller data
    assign rd_data = mem_rsp_data;

    request_scheduler #(
        .rd_frame_words(rd_frame_words)
    ) u_sched (
        .clk(clk),
        .rst(rst),
        .sample(sample),
        .sample_valid(sample_valid),
        .mem_busy(mem_busy),
        .mem_complete(mem_complete),
        .rd_almost_full(rd_almost_full),
        .head_cmd(head_cmd),
        .wb_empty(wb_empty),
        .wb_head(wb_head),
        .acc_word(acc_word),
        .sample_ready(sample_ready),
        .mem_req(mem_req),
        .mem_en(mem_en),
        .cmd_push(cmd_push),
        .cmd_push_en(cmd_push_en),
        .wb_push_en(wb_push_en),
        .wb_pop(wb_pop),
        .rd_valid(rd_valid),
        .rd_last(rd_last)
    );

    pixel_accumulate u_accum (
        .head_cmd(head_cmd),
        .mem_rsp_data(mem_rsp_data),
        .acc_word(acc_word)
    );

    // pops in step with completions, which return in issue order
    command_fifo #(
        .cmd_type(cmd_t),
        .depth(`TG_CMD_DEPTH)
    ) u_cmd_q (
        .clk(clk),
        .rst(rst),
        .write(cmd_push_en),
        .din(cmd_push),
        .read(mem_complete),
        .dout(head_cmd),
        .full(),
        .empty()
    );

    command_fifo #(
        .cmd_type(wb_t),
        .depth(`TG_WB_DEPTH)
    ) u_wb_q (
        .clk(clk),
        .rst(rst),
        .write(wb_push_en),
        .din(wb_push),
        .read(wb_pop),
        .dout(wb_head),
        .full(),
        .empty(wb_empty)
    );

endmodule

// ==== tests/tb_memory_model.sv ====
`include "tg_defines.svh"

module tb_memory_model
    import tg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  mem_req_t              mem_req,
    input  logic                  mem_en,
    output logic                  mem_busy,
    output logic                  mem_complete,
    output logic [`TG_DATA_W-1:0] mem_rsp_data,
    input  logic [`TG_ADDR_W-1:0] peek_addr,
    output logic [`TG_DATA_W-1:0] peek_data
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int latency = 4;

    // sparse backing store, absent words read as zero
    logic [`TG_DATA_W-1:0] words [logic [`TG_ADDR_W-1:0]];
    logic [31:0] lcg_state = 32'd74213;
    logic busy_q = 1'b0;
    logic pipe_valid [latency] = '{default: 1'b0};
    logic [`TG_DATA_W-1:0] pipe_data [latency] = '{default: '0};
    logic [`TG_DATA_W-1:0] peek_q = '0;
    logic accept;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    // display word pattern, every field depends on the full address
    function automatic logic [`TG_DATA_W-1:0] init_word(input logic [`TG_ADDR_W-1:0] addr);
        logic [31:0] a;
        a = {8'h00, addr};
        return {a ^ 32'h5a5a_0000, a * 32'h0101_0101, ~a, a};
    endfunction

    // display buffer words 0 to 7
    initial begin
        for (int i = 0; i < 8; i++) begin
            words[24'(i)] = init_word(24'(i));
        end
    end

    assign accept = mem_en && !busy_q;
    assign mem_busy = busy_q;
    // completions leave the end of a fixed-length pipe, so order is kept
    assign mem_complete = pipe_valid[latency-1];
    assign mem_rsp_data = pipe_data[latency-1];
    assign peek_data = peek_q;

    always @(posedge clk) begin
        if (rst) begin
            lcg_state <= 32'd74213;
            busy_q <= 1'b0;
            for (int i = 0; i < latency; i++) begin
                pipe_valid[i] <= 1'b0;
                pipe_data[i] <= '0;
            end
        end else begin
            lcg_state <= lcg_next(lcg_state);
            // busy on about one cycle in four
            busy_q <= (lcg_state[17:16] == 2'b00);
            for (int i = 1; i < latency; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
                pipe_data[i] <= pipe_data[i-1];
            end
            pipe_valid[0] <= accept;
            pipe_data[0] <= '0;
            if (accept) begin
                // read data is taken before a write to the same word lands
                if (words.exists(mem_req.addr)) begin
                    pipe_data[0] <= words[mem_req.addr];
                end
                if (mem_req.we) begin
                    words[mem_req.addr] = mem_req.wdata;
                end
            end
        end
        peek_q <= words.exists(peek_addr) ? words[peek_addr] : '0;
    end

endmodule

// ==== tests/tb_traffic_generator.sv ====
`include "tg_defines.svh"

module tb_traffic_generator
    import tg_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int frame_words = 8;
    localparam int num_entries = 9;
    localparam int num_rounds = 4;
    localparam int timeout_cycles = 40 * num_entries + 400;

    // one sample and the lane value expected after its writeback
    typedef struct packed {
        logic [3:0]            round;
        logic [`TG_ADDR_W-1:0] addr;
        logic [`TG_PIX_W-1:0]  color;
        logic                  last;
        logic [`TG_LANE_W-1:0] lane;
    } test_entry_t;

    logic clk = 1'b0;
    logic rst;
    sample_t sample;
    logic sample_valid;
    logic sample_ready;
    mem_req_t mem_req;
    logic mem_en;
    logic mem_busy;
    logic mem_complete;
    logic [`TG_DATA_W-1:0] mem_rsp_data;
    logic [`TG_DATA_W-1:0] rd_data;
    logic rd_valid;
    logic rd_last;
    logic rd_almost_full;
    logic [`TG_ADDR_W-1:0] peek_addr;
    logic [`TG_DATA_W-1:0] peek_data;

    test_entry_t stim_table [num_entries];
    // running sums per accumulator word
    logic [`TG_DATA_W-1:0] expected_words [logic [`TG_ADDR_W-1:0]];
    int cycle_count = 0;
    int write_count = 0;
    int next_disp_req = 0;
    int next_disp_rsp = 0;
    int frames_seen = 0;

    always #5 clk = ~clk;

    traffic_generator #(
        .rd_frame_words(frame_words)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .sample(sample),
        .sample_valid(sample_valid),
        .sample_ready(sample_ready),
        .mem_req(mem_req),
        .mem_en(mem_en),
        .mem_busy(mem_busy),
        .mem_complete(mem_complete),
        .mem_rsp_data(mem_rsp_data),
        .rd_data(rd_data),
        .rd_valid(rd_valid),
        .rd_last(rd_last),
        .rd_almost_full(rd_almost_full)
    );

    tb_memory_model u_mem (
        .clk(clk),
        .rst(rst),
        .mem_req(mem_req),
        .mem_en(mem_en),
        .mem_busy(mem_busy),
        .mem_complete(mem_complete),
        .mem_rsp_data(mem_rsp_data),
        .peek_addr(peek_addr),
        .peek_data(peek_data)
    );

    task automatic end_with_failure();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [`TG_DATA_W-1:0] expected,
            input logic [`TG_DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    // expected display word at a frame address
    function automatic logic [`TG_DATA_W-1:0] display_word(input logic [`TG_ADDR_W-1:0] addr);
        logic [31:0] a;
        a = {8'h00, addr};
        return {a ^ 32'h5a5a_0000, a * 32'h0101_0101, ~a, a};
    endfunction

    // two pixels share one word in the accumulator region
    function automatic logic [`TG_ADDR_W-1:0] word_addr(input logic [`TG_ADDR_W-1:0] pixel);
        return (pixel >> 1) | (24'd1 << `TG_ACCUM_BASE_BIT);
    endfunction

    // odd pixel in the low lane; fields are red, green, blue from bit 0 up
    function automatic logic [`TG_DATA_W-1:0] apply_sample(input logic [`TG_DATA_W-1:0] word,
            input logic [`TG_ADDR_W-1:0] pixel, input logic [15:0] color, input logic last);
        logic [63:0] lane;
        logic [20:0] red;
        logic [21:0] green;
        logic [20:0] blue;
        lane = pixel[0] ? word[63:0] : word[127:64];
        red = last ? 21'd0 : lane[20:0];
        green = last ? 22'd0 : lane[42:21];
        blue = last ? 21'd0 : lane[63:43];
        red = red + 21'(color[4:0]);
        green = green + 22'(color[10:5]);
        blue = blue + 21'(color[15:11]);
        lane = {blue, green, red};
        if (pixel[0]) begin
            word[63:0] = lane;
        end else begin
            word[127:64] = lane;
        end
        return word;
    endfunction

    // round, pixel, rgb565, last, lane after the round
    task automatic load_table();
        stim_table[0] = '{4'd0, 24'h000010, 16'h0841, 1'b0, 64'h0000_0800_0040_0001};
        stim_table[1] = '{4'd0, 24'h000021, 16'h0841, 1'b0, 64'h0000_0800_0040_0001};
        stim_table[2] = '{4'd0, 24'h000032, 16'hffff, 1'b1, 64'h0000_f800_07e0_001f};
        stim_table[3] = '{4'd1, 24'h000010, 16'h0841, 1'b0, 64'h0000_1000_0080_0002};
        stim_table[4] = '{4'd1, 24'h000032, 16'h0841, 1'b0, 64'h0001_0000_0820_0020};
        stim_table[5] = '{4'd2, 24'h000011, 16'hffff, 1'b0, 64'h0000_f800_07e0_001f};
        stim_table[6] = '{4'd2, 24'h000021, 16'h0841, 1'b1, 64'h0000_0800_0040_0001};
        stim_table[7] = '{4'd3, 24'h000033, 16'h0021, 1'b0, 64'h0000_0000_0020_0001};
        stim_table[8] = '{4'd3, 24'h000020, 16'h0841, 1'b0, 64'h0000_0800_0040_0001};
    endtask

    // called just after a rising edge, returns on the handshake edge
    task automatic send_sample(input test_entry_t entry);
        sample <= '{addr: entry.addr, color: entry.color, last: entry.last};
        sample_valid <= 1'b1;
        @(posedge clk);
        while (!sample_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic read_model_word(input logic [`TG_ADDR_W-1:0] addr,
            output logic [`TG_DATA_W-1:0] data);
        peek_addr <= addr;
        repeat (2) @(posedge clk);
        data = peek_data;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the test did not finish within %0d cycles", timeout_cycles);
            end_with_failure();
        end
    end

    // bus monitor, samples the values that were stable before the edge
    always @(posedge clk) begin
        if (rst) begin
            check_value("idle in reset", '0, 128'({mem_en, sample_ready, rd_valid}));
        end else begin
            if (mem_en && !mem_busy) begin
                if (mem_req.we) begin
                    write_count <= write_count + 1;
                end else if (!mem_req.addr[`TG_ACCUM_BASE_BIT]) begin
                    if (rd_almost_full) begin
                        $display("display read issued while rd_almost_full was high");
                        end_with_failure();
                    end
                    check_value("display request address", 128'(next_disp_req),
                        128'(mem_req.addr));
                    next_disp_req <= (next_disp_req + 1) % frame_words;
                end
            end
            if (rd_valid) begin
                check_value("display data", display_word(24'(next_disp_rsp)), rd_data);
                check_value("display last", 128'(next_disp_rsp == frame_words - 1),
                    128'(rd_last));
                if (rd_last) begin
                    frames_seen <= frames_seen + 1;
                end
                next_disp_rsp <= (next_disp_rsp + 1) % frame_words;
            end
        end
    end

    initial begin
        int r;
        int i;
        int total_samples;
        logic [`TG_ADDR_W-1:0] waddr;
        logic [`TG_DATA_W-1:0] word;
        logic [`TG_LANE_W-1:0] lane;
        rst <= 1'b1;
        sample <= '0;
        sample_valid <= 1'b0;
        rd_almost_full <= 1'b0;
        peek_addr <= '0;
        total_samples = 0;
        load_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (r = 0; r < num_rounds; r++) begin
            // display stream backs up for the whole of round two
            if (r == 2) begin
                rd_almost_full <= 1'b1;
            end
            for (i = 0; i < num_entries; i++) begin
                if (stim_table[i].round == r) begin
                    send_sample(stim_table[i]);
                    waddr = word_addr(stim_table[i].addr);
                    word = expected_words.exists(waddr) ? expected_words[waddr] : '0;
                    expected_words[waddr] = apply_sample(word, stim_table[i].addr,
                        stim_table[i].color, stim_table[i].last);
                    total_samples++;
                end
            end
            sample_valid <= 1'b0;
            // every sample ends in exactly one accepted write
            while (write_count < total_samples) begin
                @(posedge clk);
            end
            for (i = 0; i < num_entries; i++) begin
                if (stim_table[i].round == r) begin
                    read_model_word(word_addr(stim_table[i].addr), word);
                    lane = stim_table[i].addr[0] ? word[63:0] : word[127:64];
                    check_value($sformatf("round %0d pixel %h lane", r, stim_table[i].addr),
                        128'(stim_table[i].lane), 128'(lane));
                end
            end
            rd_almost_full <= 1'b0;
        end
        // let display reads run on and catch any stray writes
        repeat (40) @(posedge clk);
        check_value("write count", 128'(total_samples), 128'(write_count));
        if (frames_seen < 2) begin
            $display("display stream delivered fewer than two whole frames");
            end_with_failure();
        end
        foreach (expected_words[a]) begin
            read_model_word(a, word);
            check_value($sformatf("final word %h", a), expected_words[a], word);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/tg_pkg.sv
hw/command_fifo.sv
hw/pixel_accumulate.sv
hw/request_scheduler.sv
hw/traffic_generator.sv
tests/tb_memory_model.sv
tests/tb_traffic_generator.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the traffic generator testbench with verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/100ps -j 0 \
    --top-module tb_traffic_generator -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_traffic_generator > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
